// File: tests/membridge_tests.txt
# name lo64 size64 start64 len64 (hex) mode stall bursts (dec) final_addr final_len (hex)
# mode 0 = fresh start, 1 = continue; stall 1 = random credit and source stalls
short     100 40  0  5   0 0 1 800  4
multi     200 100 20 35  0 0 4 1280 4
rollover  400 40  30 28  0 0 3 2080 7
continue  400 40  0  14  1 0 2 2140 3
stall     800 80  10 30  0 1 3 4180 f
stall_rol 0   20  10 13  0 1 2 0    2

// File: sim.f
design/membridge_regs_pkg.sv
design/membridge_bus_pkg.sv
design/xfer_if.sv
design/membridge_ctrl.sv
design/burst_planner.sv
design/beat_framer.sv
design/completion_monitor.sv
design/membridge_top.sv
tests/membridge_checker.sv
tests/tb_membridge.sv

// File: Bender.yml
package:
  name: membridge

sources:
  - design/membridge_regs_pkg.sv
  - design/membridge_bus_pkg.sv
  - design/xfer_if.sv
  - design/membridge_ctrl.sv
  - design/burst_planner.sv
  - design/beat_framer.sv
  - design/completion_monitor.sv
  - design/membridge_top.sv
  - target: test
    files:
      - tests/membridge_checker.sv
      - tests/tb_membridge.sv

// File: tests/tb_membridge.sv
// testbench for the memory write bridge
// file-driven tests, register programming, LFSR data and stalls
// credit return, write responses, status checks
`timescale 1ns/1ps

module tb_membridge;

    localparam int AW_CR = 2;   // small pools so credits run dry
    localparam int W_CR  = 4;
    localparam int DEPTH = 4;

    logic                        hclk;
    logic                        rst;
    logic                        reg_we_i;
    membridge_regs_pkg::reg_op_e reg_addr_i;
    logic [31:0]                 reg_wdata_i;
    logic                        src_valid_i;
    logic [63:0]                 src_data_i;
    logic                        src_credit_o;
    logic                        aw_credit_i;
    logic                        aw_valid_o;
    logic [31:0]                 aw_addr_o;
    logic [3:0]                  aw_len_o;
    logic                        w_credit_i;
    logic                        w_valid_o;
    logic [63:0]                 w_data_o;
    logic                        w_last_o;
    logic                        b_valid_i;
    logic                        busy_o;
    logic                        done_o;

    logic [15:0] lfsr = 16'd35;  // seed
    bit          stall_mode = 0;
    bit          timed_out = 0;
    int          stall_cnt = 0;
    int          words_left = 0;  // words the source still owes
    int          src_credits = DEPTH;
    int          aw_owed = 0;     // credits to hand back
    int          w_owed = 0;
    int          aw_seen = 0;
    int          last_seen = 0;
    int          b_sent = 0;
    int          b_wait = 0;
    int          tb_errs = 0;

    membridge_top #(.AW_CREDITS(AW_CR), .W_CREDITS(W_CR), .SRC_DEPTH(DEPTH)) DUT (.*);

    membridge_checker #(.AW_CREDITS(AW_CR), .W_CREDITS(W_CR)) u_chk (
        .hclk(hclk), .rst(rst), .src_valid_i(src_valid_i), .src_data_i(src_data_i),
        .aw_credit_i(aw_credit_i), .aw_valid_i(aw_valid_o), .aw_addr_i(aw_addr_o),
        .aw_len_i(aw_len_o), .w_credit_i(w_credit_i), .w_valid_i(w_valid_o),
        .w_data_i(w_data_o), .w_last_i(w_last_o), .busy_i(busy_o),
        .b_valid_i(b_valid_i), .done_i(done_o)
    );

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[62:0], fb};
        end
        return val;
    endfunction

    initial begin
        hclk = 1'b0;
        forever #2 hclk = ~hclk;
    end

    task automatic reg_write(input membridge_regs_pkg::reg_op_e addr, input logic [31:0] data);
        @(posedge hclk);
        #1;
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge hclk);
        #1;
        reg_we_i = 1'b0;
    endtask

    task automatic wait_status(input bit on_done, input bit level, input string what);
        for (int n = 0; n < 4000 && !timed_out; n++) begin
            @(posedge hclk);
            if ((on_done ? done_o : busy_o) == level) return;
        end
        if (!timed_out) begin
            $display("timeout while waiting for %0s", what);
            timed_out = 1'b1;
        end
    endtask

    // credit return, responses and source words, 1 ns after each edge
    initial begin
        forever begin
            @(posedge hclk);
            if (src_credit_o) src_credits++;
            if (aw_valid_o) aw_owed++;
            if (w_valid_o) w_owed++;
            if (aw_valid_o) aw_seen++;
            if (w_valid_o && w_last_o) last_seen++;
            #1;
            if (stall_cnt > 0) stall_cnt--;
            else if (stall_mode) stall_cnt = int'(lfsr_bits(3));  // stall length
            aw_credit_i = (stall_cnt == 0) && (aw_owed > 0);
            if (aw_credit_i) aw_owed--;
            w_credit_i = (stall_cnt == 0) && (w_owed > 0);
            if (w_credit_i) w_owed--;
            b_valid_i = 1'b0;
            // response only once both AW and last beat of a burst are out
            if (b_wait > 0) begin
                b_wait--;
                if (b_wait == 0) begin
                    b_valid_i = 1'b1;
                    b_sent++;
                end
            end else if (b_sent < aw_seen && b_sent < last_seen) begin
                b_wait = 3;
            end
            src_valid_i = 1'b0;
            if (words_left > 0 && src_credits > 0 && stall_cnt == 0) begin
                src_valid_i = 1'b1;
                src_data_i  = lfsr_bits(64);
                words_left--;
                src_credits--;
            end
        end
    end

    initial begin
        int           fd;
        int           cnt;
        string        line;
        logic [127:0] name;
        logic [31:0]  lo;
        logic [31:0]  size;
        logic [31:0]  start;
        logic [31:0]  len;
        logic [31:0]  addr;
        logic [31:0]  flen;
        int           mode;
        int           stall;
        int           nb;
        rst         = 1'b1;
        reg_we_i    = 1'b0;
        reg_addr_i  = membridge_regs_pkg::REG_CTRL;
        reg_wdata_i = '0;
        src_valid_i = 1'b0;
        src_data_i  = '0;
        aw_credit_i = 1'b0;
        w_credit_i  = 1'b0;
        b_valid_i   = 1'b0;
        repeat (5) @(posedge hclk);
        #1;
        rst = 1'b0;
        @(posedge hclk);
        if (aw_valid_o || w_valid_o || src_credit_o || busy_o || done_o) begin
            $display("outputs not low after reset");
            tb_errs++;
        end
        fd = $fopen("tests/membridge_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            tb_errs++;
        end
        while (fd != 0 && !timed_out && $fgets(line, fd)) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // comment
            cnt = $sscanf(line, "%s %h %h %h %h %d %d %d %h %h", name, lo, size, start, len,
                          mode, stall, nb, addr, flen);
            if (cnt != 10) continue;
            stall_mode = stall[0];
            u_chk.start_test(name, lo << 3, len, nb, addr, flen[3:0]);
            reg_write(membridge_regs_pkg::REG_LO_ADDR64, lo);
            reg_write(membridge_regs_pkg::REG_SIZE64, size);
            reg_write(membridge_regs_pkg::REG_START64, start);
            reg_write(membridge_regs_pkg::REG_LEN64, len);
            reg_write(membridge_regs_pkg::REG_CTRL, (mode == 1) ? 32'h7 : 32'h3);
            @(posedge hclk);
            words_left = len;
            wait_status(1'b0, 1'b1, "busy to rise");
            wait_status(1'b1, 1'b1, "done after the last response");
            @(posedge hclk);
            u_chk.finish_test();
            stall_mode = 0;
            reg_write(membridge_regs_pkg::REG_CTRL, 32'h0);  // disable clears done
            wait_status(1'b1, 1'b0, "done to clear on disable");
        end
        if (fd != 0) $fclose(fd);
        u_chk.report();
        if (!timed_out && u_chk.fail_cnt == 0 && tb_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tests/membridge_checker.sv
// watches the bridge ports and checks them against the transfer setup
// source word order, burst address steps and lengths, last-beat marking, credit use
// responses and busy at done, per-test result lines and closing totals
`timescale 1ns/1ps

module membridge_checker #(
    parameter int AW_CREDITS = 4,
    parameter int W_CREDITS  = 16
) (
    input logic        hclk,
    input logic        rst,
    input logic        src_valid_i,
    input logic [63:0] src_data_i,
    input logic        aw_credit_i,
    input logic        aw_valid_i,
    input logic [31:0] aw_addr_i,
    input logic [3:0]  aw_len_i,
    input logic        w_credit_i,
    input logic        w_valid_i,
    input logic [63:0] w_data_i,
    input logic        w_last_i,
    input logic        busy_i,
    input logic        b_valid_i,
    input logic        done_i
);

    logic [63:0]  exp_q [$];   // source words not yet seen on W
    logic [63:0]  exp_word;
    logic [127:0] test_name;
    logic [31:0]  lo_bytes;    // rollover target
    logic [31:0]  exp_addr;
    logic [3:0]   exp_len;
    logic [31:0]  last_addr;
    logic [3:0]   last_len;
    logic         exp_last;
    logic         done_d;      // done one cycle back, for its rising edge
    int           exp_bursts;
    int           xfer_len;
    int           bursts;
    int           beats;
    int           resps;       // B responses this test
    int           burst_beat;  // beat index within burst
    bit           busy_seen;
    int           test_errs;
    int           aw_cred;     // mirror of credits granted
    int           w_cred;
    int           fail_cnt = 0;
    int           ok_cnt = 0;

    function automatic void value_error(input string what, input logic [63:0] exp,
                                        input logic [63:0] act);
        $display("Error %0s %0s: expected %h, actual %h", test_name, what, exp, act);
        test_errs++;
    endfunction

    function automatic void plain_error(input string msg);
        $display("%0s: %0s", test_name, msg);
        test_errs++;
    endfunction

    task automatic start_test(input logic [127:0] name, input logic [31:0] lo_b,
                              input int len, input int nb, input logic [31:0] addr,
                              input logic [3:0] len_m1);
        test_name  = name;
        lo_bytes   = lo_b;
        xfer_len   = len;
        exp_bursts = nb;
        exp_addr   = addr;
        exp_len    = len_m1;
        bursts     = 0;
        beats      = 0;
        resps      = 0;
        burst_beat = 0;
        busy_seen  = 0;
        test_errs  = 0;
        last_addr  = '0;
        last_len   = '0;
    endtask

    task automatic finish_test();
        if (bursts != exp_bursts) value_error("burst count", exp_bursts, bursts);
        if (last_addr != exp_addr) value_error("final burst address", exp_addr, last_addr);
        if (last_len != exp_len) value_error("final burst length", exp_len, last_len);
        if (beats != xfer_len) value_error("beat count", xfer_len, beats);
        if (!busy_seen) plain_error("busy never went high during the transfer");
        if (exp_q.size() != 0) plain_error("source words left over after done");
        if (test_errs == 0) begin
            ok_cnt++;
            $display("%0s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("%0s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d ok, %0d with errors", ok_cnt + fail_cnt, ok_cnt,
                 fail_cnt);
    endtask

    always @(posedge hclk or posedge rst) begin
        if (rst) begin
            aw_cred = AW_CREDITS;
            w_cred  = W_CREDITS;
            done_d  = 1'b0;
        end else begin
            if (src_valid_i) exp_q.push_back(src_data_i);  // source order
            if (aw_valid_i) begin
                if (aw_cred == 0) plain_error("AW valid without a credit");
                // only the final burst of a transfer may be short
                if (bursts > 0 && last_len != 4'hf) value_error("burst length", 4'hf, last_len);
                // next block, or back to range base
                if (bursts > 0 && aw_addr_i != last_addr + 32'd128 && aw_addr_i != lo_bytes)
                    value_error("burst address", last_addr + 32'd128, aw_addr_i);
                bursts++;
                last_addr = aw_addr_i;
                last_len  = aw_len_i;
            end
            if (w_valid_i) begin
                if (w_cred == 0) plain_error("W valid without a credit");
                if (exp_q.size() == 0) begin
                    plain_error("W beat with no source word behind it");
                end else begin
                    exp_word = exp_q.pop_front();
                    if (w_data_i !== exp_word) value_error("data", exp_word, w_data_i);
                end
                exp_last = (burst_beat == 15) || (beats == xfer_len - 1);  // 16th or final
                if (w_last_i !== exp_last) value_error("w_last", exp_last, w_last_i);
                burst_beat = exp_last ? 0 : burst_beat + 1;
                beats++;
            end
            if (b_valid_i) resps++;
            if (done_i && !done_d) begin
                if (resps != bursts) value_error("responses at done", bursts, resps);
                if (busy_i) plain_error("busy still high when done rose");
            end
            done_d = done_i;
            if (busy_i) busy_seen = 1;
            aw_cred = aw_cred + aw_credit_i - aw_valid_i;
            w_cred  = w_cred + w_credit_i - w_valid_i;
        end
    end

endmodule

// File: design/membridge_top.sv
// system memory write bridge, top level
// control block, burst planner, beat framer, completion monitor
`timescale 1ns/1ps

module membridge_top #(
    parameter int AW_CREDITS = 4,
    parameter int W_CREDITS  = 16,
    parameter int SRC_DEPTH  = 4
) (
    input  logic                                      hclk,
    input  logic                                      rst,
    input  logic                                      reg_we_i,
    input  membridge_regs_pkg::reg_op_e               reg_addr_i,
    input  logic [membridge_regs_pkg::REG_DATA_W-1:0] reg_wdata_i,
    input  logic                                      src_valid_i,
    input  logic [membridge_bus_pkg::DATA_W-1:0]      src_data_i,
    output logic                                      src_credit_o,
    input  logic                                      aw_credit_i,
    output logic                                      aw_valid_o,
    output logic [membridge_bus_pkg::BYTE_ADDR_W-1:0] aw_addr_o,
    output logic [membridge_bus_pkg::BURST_LEN_W-1:0] aw_len_o,
    input  logic                                      w_credit_i,
    output logic                                      w_valid_o,
    output logic [membridge_bus_pkg::DATA_W-1:0]      w_data_o,
    output logic                                      w_last_o,
    input  logic                                      b_valid_i,
    output logic                                      busy_o,
    output logic                                      done_o
);

    logic enable;
    logic burst_issued;
    logic plan_done;
    logic beat_sent;
    logic frame_done;

    xfer_if xfer ();

    membridge_ctrl u_ctrl (
        .hclk(hclk), .rst(rst), .reg_we_i(reg_we_i), .reg_addr_i(reg_addr_i),
        .reg_wdata_i(reg_wdata_i), .enable_o(enable), .xfer_o(xfer.ctrl)
    );

    burst_planner #(.AW_CREDITS(AW_CREDITS)) u_planner (
        .hclk(hclk), .rst(rst), .xfer_i(xfer.planner), .aw_credit_i(aw_credit_i),
        .aw_valid_o(aw_valid_o), .aw_addr_o(aw_addr_o), .aw_len_o(aw_len_o),
        .burst_issued_o(burst_issued), .plan_done_o(plan_done)
    );

    beat_framer #(.W_CREDITS(W_CREDITS), .SRC_DEPTH(SRC_DEPTH)) u_framer (
        .hclk(hclk), .rst(rst), .xfer_i(xfer.framer), .src_valid_i(src_valid_i),
        .src_data_i(src_data_i), .src_credit_o(src_credit_o), .w_credit_i(w_credit_i),
        .w_valid_o(w_valid_o), .w_data_o(w_data_o), .w_last_o(w_last_o),
        .beat_sent_o(beat_sent), .frame_done_o(frame_done)
    );

    completion_monitor u_monitor (
        .hclk(hclk), .rst(rst), .enable_i(enable), .burst_issued_i(burst_issued),
        .plan_done_i(plan_done), .beat_sent_i(beat_sent), .frame_done_i(frame_done),
        .b_valid_i(b_valid_i), .busy_o(busy_o), .done_o(done_o)
    );

endmodule

// File: design/completion_monitor.sv
// matches issued bursts against write responses
// busy and done status of the current transfer
`timescale 1ns/1ps

module completion_monitor (
    input  logic hclk,
    input  logic rst,
    input  logic enable_i,
    input  logic burst_issued_i,
    input  logic plan_done_i,
    input  logic beat_sent_i,
    input  logic frame_done_i,
    input  logic b_valid_i,
    output logic busy_o,
    output logic done_o
);

    localparam int AW = membridge_regs_pkg::ADDR64_W;

    logic [AW-1:0] burst_cnt;    // AWs sent this transfer
    logic [AW-1:0] resp_cnt;     // B responses seen
    logic          plan_done_d;
    logic          new_xfer;
    logic          complete;

    assign new_xfer = plan_done_d && !plan_done_i;  // planner cleared by a start
    assign complete = busy_o && !burst_issued_i && plan_done_i && frame_done_i &&
                      (burst_cnt == resp_cnt);  // an AW on the wire is not yet counted

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            burst_cnt   <= '0;
            resp_cnt    <= '0;
            plan_done_d <= 1'b0;
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            plan_done_d <= plan_done_i;
            if (new_xfer) begin
                burst_cnt <= '0;
                resp_cnt  <= '0;
            end else begin
                if (burst_issued_i) begin
                    burst_cnt <= burst_cnt + 1'b1;
                end
                if (b_valid_i) begin
                    resp_cnt <= resp_cnt + 1'b1;
                end
            end
            if (complete || new_xfer) begin
                busy_o <= 1'b0;
            end else if (burst_issued_i || beat_sent_i) begin
                busy_o <= 1'b1;  // W may lead AW
            end
            if (!enable_i) begin
                done_o <= 1'b0;  // disable clears status
            end else if (complete) begin
                done_o <= 1'b1;
            end else if (new_xfer) begin
                done_o <= 1'b0;
            end
        end
    end

    // a response always follows an AW that the planner issued
    assert property (@(posedge hclk) disable iff (rst) b_valid_i |-> burst_cnt != resp_cnt);

endmodule

// File: design/beat_framer.sv
// staging FIFO for source words, source credit return
// W credit counting and last-beat marking per burst
`timescale 1ns/1ps

module beat_framer #(
    parameter int W_CREDITS = 16,
    parameter int SRC_DEPTH = 4
) (
    input  logic                                 hclk,
    input  logic                                 rst,
    xfer_if.framer                               xfer_i,
    input  logic                                 src_valid_i,
    input  logic [membridge_bus_pkg::DATA_W-1:0] src_data_i,
    output logic                                 src_credit_o,
    input  logic                                 w_credit_i,
    output logic                                 w_valid_o,
    output logic [membridge_bus_pkg::DATA_W-1:0] w_data_o,
    output logic                                 w_last_o,
    output logic                                 beat_sent_o,
    output logic                                 frame_done_o
);

    localparam int AW = membridge_regs_pkg::ADDR64_W;
    localparam int LW = membridge_bus_pkg::BURST_LEN_W;
    localparam int PW = $clog2(SRC_DEPTH);
    localparam int FW = $clog2(SRC_DEPTH + 1);
    localparam int CW = $clog2(W_CREDITS + 1);

    logic [membridge_bus_pkg::DATA_W-1:0] fifo_mem [SRC_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [FW-1:0] fill;      // words held
    logic [CW-1:0] credits;   // W credits
    logic [AW-1:0] left64;    // words still to send
    logic [LW-1:0] beat_cnt;  // beat within burst
    logic          pop;

    assign pop          = (fill != '0) && (credits != '0) && (left64 != '0);
    assign beat_sent_o  = w_valid_o;
    assign src_credit_o = w_valid_o;  // slot freed by this beat

    always_ff @(posedge hclk) begin
        if (src_valid_i) begin
            fifo_mem[wr_ptr] <= src_data_i;
        end
        if (pop) begin
            w_data_o <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            credits      <= CW'(W_CREDITS);
            left64       <= '0;
            beat_cnt     <= '0;
            w_valid_o    <= 1'b0;
            w_last_o     <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            if (src_valid_i) begin
                wr_ptr <= (wr_ptr == PW'(SRC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(SRC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill      <= fill + FW'(src_valid_i) - FW'(pop);
            credits   <= credits + CW'(w_credit_i) - CW'(pop);
            w_valid_o <= pop;
            w_last_o  <= pop && ((&beat_cnt) || (left64 == AW'(1)));  // 16th or final
            if (xfer_i.start) begin
                left64       <= xfer_i.len64;
                beat_cnt     <= '0;
                frame_done_o <= (xfer_i.len64 == '0);
            end else if (pop) begin
                left64   <= left64 - 1'b1;
                beat_cnt <= beat_cnt + 1'b1;
                if (left64 == AW'(1)) begin
                    frame_done_o <= 1'b1;
                end
            end
        end
    end

    // source keeps its credit count, so it never pushes into a full FIFO
    assert property (@(posedge hclk) disable iff (rst)
        src_valid_i |-> fill != FW'(SRC_DEPTH));

    // W credits come back only for beats already sent so the count never wraps
    assert property (@(posedge hclk) disable iff (rst)
        w_credit_i |-> credits != CW'(W_CREDITS));

endmodule

// File: design/burst_planner.sv
// splits a transfer into bursts of up to 16 words
// relative address with range rollover, AW credits and AW issue
`timescale 1ns/1ps

module burst_planner #(
    parameter int AW_CREDITS = 4
) (
    input  logic                                      hclk,
    input  logic                                      rst,
    xfer_if.planner                                   xfer_i,
    input  logic                                      aw_credit_i,
    output logic                                      aw_valid_o,
    output logic [membridge_bus_pkg::BYTE_ADDR_W-1:0] aw_addr_o,
    output logic [membridge_bus_pkg::BURST_LEN_W-1:0] aw_len_o,
    output logic                                      burst_issued_o,
    output logic                                      plan_done_o
);

    localparam int AW = membridge_regs_pkg::ADDR64_W;
    localparam int LW = membridge_bus_pkg::BURST_LEN_W;
    localparam int BW = LW + 1;  // word count, up to 16
    localparam int CW = $clog2(AW_CREDITS + 1);

    membridge_bus_pkg::planner_state_e state;

    logic [AW-1:0] rel64;     // relative to range low
    logic [AW-1:0] left64;    // words not yet planned
    logic [BW-1:0] burst_w;   // words in current burst
    logic [BW-1:0] len_m1;
    logic          rollover;  // current block is last of the range
    logic [CW-1:0] credits;
    logic          issue;

    assign issue = ((state == membridge_bus_pkg::ISSUE) ||
                    (state == membridge_bus_pkg::WAIT_CREDIT)) && (credits != '0);
    assign len_m1         = burst_w - 1'b1;
    assign aw_len_o       = len_m1[LW-1:0];
    assign burst_issued_o = aw_valid_o;

    // burst fields, held stable while aw_valid_o is up
    always_ff @(posedge hclk) begin
        if (state == membridge_bus_pkg::CALC) begin
            burst_w   <= (|left64[AW-1:LW]) ? BW'(membridge_bus_pkg::BURST_WORDS)
                                            : {1'b0, left64[LW-1:0]};
            rollover  <= rel64[AW-1:LW] == (xfer_i.size64[AW-1:LW] - 1'b1);
            aw_addr_o <= {xfer_i.lo_addr64 + rel64, 3'b000};  // words to bytes
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            state       <= membridge_bus_pkg::IDLE;
            rel64       <= '0;
            left64      <= '0;
            credits     <= CW'(AW_CREDITS);
            aw_valid_o  <= 1'b0;
            plan_done_o <= 1'b0;
        end else begin
            credits    <= credits + CW'(aw_credit_i) - CW'(issue);
            aw_valid_o <= issue;
            if (xfer_i.start) begin
                if (xfer_i.reset_addr) begin
                    rel64 <= xfer_i.start64;  // else resume where last ended
                end
                left64      <= xfer_i.len64;
                plan_done_o <= (xfer_i.len64 == '0);
                state       <= (xfer_i.len64 == '0) ? membridge_bus_pkg::IDLE
                                                    : membridge_bus_pkg::CALC;
            end else begin
                if (state == membridge_bus_pkg::CALC) begin
                    state <= membridge_bus_pkg::ISSUE;
                end else if (state == membridge_bus_pkg::ISSUE && !issue) begin
                    state <= membridge_bus_pkg::WAIT_CREDIT;
                end
                if (issue) begin
                    left64 <= left64 - AW'(burst_w);
                    if (burst_w != BW'(membridge_bus_pkg::BURST_WORDS)) begin
                        rel64 <= rel64 + AW'(burst_w);  // partial tail, kept for continue
                    end else if (rollover) begin
                        rel64 <= '0;
                    end else begin
                        rel64 <= rel64 + AW'(membridge_bus_pkg::BURST_WORDS);
                    end
                    if (left64 == AW'(burst_w)) begin
                        plan_done_o <= 1'b1;
                        state       <= membridge_bus_pkg::IDLE;
                    end else begin
                        state <= membridge_bus_pkg::CALC;
                    end
                end
            end
        end
    end

    // credits come back only for AWs in flight so the count never wraps
    assert property (@(posedge hclk) disable iff (rst)
        aw_credit_i |-> credits != CW'(AW_CREDITS));

endmodule

// File: design/membridge_ctrl.sv
// register write decoding for the memory bridge
// aligned setup registers, enable bit, start pulse
`timescale 1ns/1ps

module membridge_ctrl (
    input  logic                                      hclk,
    input  logic                                      rst,
    input  logic                                      reg_we_i,
    input  membridge_regs_pkg::reg_op_e               reg_addr_i,
    input  logic [membridge_regs_pkg::REG_DATA_W-1:0] reg_wdata_i,
    output logic                                      enable_o,
    xfer_if.ctrl                                      xfer_o
);

    localparam int AW = membridge_regs_pkg::ADDR64_W;

    logic          set_ctrl;
    logic          set_lo;
    logic          set_size;
    logic          set_start;
    logic          set_len;
    logic [AW-1:0] wd_aligned;

    assign set_ctrl   = reg_we_i && (reg_addr_i == membridge_regs_pkg::REG_CTRL);
    assign set_lo     = reg_we_i && (reg_addr_i == membridge_regs_pkg::REG_LO_ADDR64);
    assign set_size   = reg_we_i && (reg_addr_i == membridge_regs_pkg::REG_SIZE64);
    assign set_start  = reg_we_i && (reg_addr_i == membridge_regs_pkg::REG_START64);
    assign set_len    = reg_we_i && (reg_addr_i == membridge_regs_pkg::REG_LEN64);
    assign wd_aligned = {reg_wdata_i[AW-1:4], 4'b0000};  // 16-word boundary

    always_ff @(posedge hclk) begin
        if (set_lo) begin
            xfer_o.lo_addr64 <= wd_aligned;
        end
        if (set_size) begin
            xfer_o.size64 <= wd_aligned;
        end
        if (set_lo) begin
            xfer_o.start64 <= '0;  // new range, restart at its base
        end else if (set_start) begin
            xfer_o.start64 <= wd_aligned;
        end
        if (set_len) begin
            xfer_o.len64 <= reg_wdata_i[AW-1:0];  // any length
        end
        if (set_ctrl) begin
            xfer_o.reset_addr <= reg_wdata_i[membridge_regs_pkg::CTRL_START_BIT] &&
                                 !reg_wdata_i[membridge_regs_pkg::CTRL_CONTINUE_BIT];
        end
    end

    always_ff @(posedge hclk or posedge rst) begin
        if (rst) begin
            enable_o     <= 1'b0;
            xfer_o.start <= 1'b0;
        end else begin
            if (set_ctrl) begin
                enable_o <= reg_wdata_i[membridge_regs_pkg::CTRL_ENABLE_BIT];
            end
            // pulse lines up with the setup written on the same edge
            xfer_o.start <= set_ctrl && reg_wdata_i[membridge_regs_pkg::CTRL_START_BIT];
        end
    end

endmodule

// File: design/xfer_if.sv
// transfer setup latched by the control block
// start event toward the planner and the framer
`timescale 1ns/1ps

interface xfer_if;

    logic                                    start;       // one-cycle pulse
    logic                                    reset_addr;  // 0 = continue from last end
    logic [membridge_regs_pkg::ADDR64_W-1:0] lo_addr64;
    logic [membridge_regs_pkg::ADDR64_W-1:0] size64;
    logic [membridge_regs_pkg::ADDR64_W-1:0] start64;
    logic [membridge_regs_pkg::ADDR64_W-1:0] len64;

    modport ctrl (output start, reset_addr, lo_addr64, size64, start64, len64);

    modport planner (input start, reset_addr, lo_addr64, size64, start64, len64);

    modport framer (input start, len64);

endinterface

// File: design/membridge_bus_pkg.sv
// burst geometry of the system memory write path
// burst planner FSM states
package membridge_bus_pkg;

    localparam int BURST_WORDS = 16;  // max words per burst
    localparam int BURST_LEN_W = 4;   // aw_len field, words - 1
    localparam int BYTE_ADDR_W = 32;
    localparam int DATA_W      = 64;

    typedef enum logic [1:0] {
        IDLE,         // nothing left to plan
        CALC,         // build address and length of next burst
        ISSUE,        // send AW if a credit is held
        WAIT_CREDIT   // stalled, no AW credit
    } planner_state_e;

endpackage

// File: design/membridge_regs_pkg.sv
// register map of the bridge control block
// control word bit positions and setup field widths
package membridge_regs_pkg;

    typedef enum logic [3:0] {
        REG_CTRL      = 4'd0,  // enable, start, continue
        REG_LO_ADDR64 = 4'd2,  // range low, 64-bit words
        REG_SIZE64    = 4'd3,  // range size, 64-bit words
        REG_START64   = 4'd4,  // offset from range low
        REG_LEN64     = 4'd5   // transfer length, 64-bit words
    } reg_op_e;

    localparam int REG_DATA_W = 32;  // register write data
    localparam int ADDR64_W   = 29;  // word address or length

    // control word, bits 2:1 = 01 start fresh, 11 continue
    localparam int CTRL_ENABLE_BIT   = 0;
    localparam int CTRL_START_BIT    = 1;
    localparam int CTRL_CONTINUE_BIT = 2;

    // low, size and start are kept 16-word aligned, length is not

endpackage
